// ==== sim/cd_link_chk.sv ====
// Concurrent assertions on outbound messages, reply pulses, counters and download spacing
`timescale 1ns/1ps
`default_nettype none

module cd_link_chk
	import cd_link_pkg::*;
#(
	parameter int CNT_W = 8
) (
	input logic              clk_sys,
	input logic              reset,
	input logic              cmd_send,
	input logic [CMD_W-1:0]  cmd_data,
	input logic              dout_send,
	input logic [DOUT_W-1:0] dout_data,
	input logic              drive_reset_req,
	input logic              fast_seek,
	input host_msg_t         host_out,
	input host_reply_t       host_in,
	input logic [7:0]        drive_stat,
	input logic [7:0]        drive_msg,
	input logic              stat_get,
	input logic              dout_req,
	input logic [CNT_W-1:0]  stat_cnt,
	input logic [CNT_W-1:0]  comm_cnt,
	input logic              dl_wr,
	input logic              cd_byte_wr
);

	int unsigned fail_cnt = 0;

	logic              cmd_q, dout_q, drv_rst_q;
	logic              cmd_rise, dout_rise, drv_rst_rise, any_rise, any_rise_q;
	logic              reply_tog_q, new_reply, reply_q, reply_dout_q;
	logic              toggle_q, fast_seek_q;
	logic [CMD_W-1:0]  cmd_data_q, payload_q;
	logic [DOUT_W-1:0] dout_data_q;
	logic [7:0]        stat_q, msg_q;
	logic [CNT_W-1:0]  cmd_total, cmd_total_d, stat_total;

	assign cmd_rise     = cmd_send & ~cmd_q;
	assign dout_rise    = dout_send & ~dout_q;
	assign drv_rst_rise = drive_reset_req & ~drv_rst_q;
	assign any_rise     = cmd_rise | dout_rise | drv_rst_rise;
	assign new_reply    = host_in.toggle != reply_tog_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cmd_q       <= 1'b0;
			dout_q      <= 1'b0;
			drv_rst_q   <= 1'b0;
			any_rise_q  <= 1'b0;
			reply_tog_q <= 1'b0;
			reply_q     <= 1'b0;
			cmd_total   <= '0;
			cmd_total_d <= '0;
			stat_total  <= '0;
		end else begin
			cmd_q       <= cmd_send;
			dout_q      <= dout_send;
			drv_rst_q   <= drive_reset_req;
			any_rise_q  <= any_rise;
			reply_tog_q <= host_in.toggle;
			reply_q     <= new_reply;
			// comm_cnt trails the request edge by two cycles
			cmd_total   <= cmd_total + cmd_rise;
			cmd_total_d <= cmd_total;
			stat_total  <= stat_total + new_reply;
		end
	end

	// Values one cycle back, for the expected side
	always_ff @(posedge clk_sys) begin
		toggle_q     <= host_out.toggle;
		fast_seek_q  <= fast_seek;
		cmd_data_q   <= cmd_data;
		payload_q    <= host_out.payload;
		dout_data_q  <= dout_data;
		reply_dout_q <= host_in.is_dataout;
		stat_q       <= host_in.stat;
		msg_q        <= host_in.msg;
	end

	//////////////////////////////////////////////////////////////////////
	// Properties
	//////////////////////////////////////////////////////////////////////

	a_reset_state: assert property (@(posedge clk_sys) reset |=> !stat_get && !dout_req
		&& !cd_byte_wr && stat_cnt == '0 && comm_cnt == '0 && !host_out.toggle)
	else begin
		$error("ERROR %0t reset state got pulses %b%b%b cnt %0d/%0d toggle %b exp all 0",
			$time, $sampled(stat_get), $sampled(dout_req), $sampled(cd_byte_wr),
			$sampled(stat_cnt), $sampled(comm_cnt), $sampled(host_out.toggle));
		fail_cnt++;
	end

	// One toggle flip per winning edge, none while a request is held
	a_toggle: assert property (@(posedge clk_sys) disable iff (reset)
		host_out.toggle == (toggle_q ^ any_rise_q))
	else begin
		$error("ERROR %0t host_out.toggle got %b exp %b", $time,
			$sampled(host_out.toggle), $sampled(toggle_q ^ any_rise_q));
		fail_cnt++;
	end

	a_cmd_msg: assert property (@(posedge clk_sys) !reset && cmd_rise |=>
		host_out.payload == cmd_data_q && host_out.kind == {fast_seek_q, 15'd0})
	else begin
		$error("ERROR %0t host_out payload/kind got %h/%h exp %h/%h", $time,
			$sampled(host_out.payload), $sampled(host_out.kind),
			$sampled(cmd_data_q), {$sampled(fast_seek_q), 15'd0});
		fail_cnt++;
	end

	a_dout_msg: assert property (@(posedge clk_sys) !reset && dout_rise && !cmd_rise |=>
		host_out.kind == MSG_DATAOUT
		&& host_out.payload == {payload_q[CMD_W-1:DOUT_W], dout_data_q})
	else begin
		$error("ERROR %0t host_out payload/kind got %h/%h exp %h/%h", $time,
			$sampled(host_out.payload), $sampled(host_out.kind),
			$sampled({payload_q[CMD_W-1:DOUT_W], dout_data_q}), MSG_DATAOUT);
		fail_cnt++;
	end

	// Drive reset leaves the whole payload alone
	a_reset_msg: assert property (@(posedge clk_sys)
		!reset && drv_rst_rise && !cmd_rise && !dout_rise |=>
		host_out.kind == MSG_RESET && host_out.payload == payload_q)
	else begin
		$error("ERROR %0t host_out payload/kind got %h/%h exp %h/%h", $time,
			$sampled(host_out.payload), $sampled(host_out.kind),
			$sampled(payload_q), MSG_RESET);
		fail_cnt++;
	end

	a_counters: assert property (@(posedge clk_sys) disable iff (reset)
		comm_cnt == cmd_total_d && stat_cnt == stat_total)
	else begin
		$error("ERROR %0t comm_cnt/stat_cnt got %0d/%0d exp %0d/%0d", $time,
			$sampled(comm_cnt), $sampled(stat_cnt), $sampled(cmd_total_d),
			$sampled(stat_total));
		fail_cnt++;
	end

	a_reply: assert property (@(posedge clk_sys) disable iff (reset)
		stat_get == (reply_q & ~reply_dout_q) && dout_req == (reply_q & reply_dout_q)
		&& (!reply_q || (drive_stat == stat_q && drive_msg == msg_q)))
	else begin
		$error("ERROR %0t stat_get/dout_req/drive_stat/drive_msg got %b/%b/%h/%h exp %b/%b/%h/%h",
			$time, $sampled(stat_get), $sampled(dout_req), $sampled(drive_stat),
			$sampled(drive_msg), $sampled(reply_q & ~reply_dout_q),
			$sampled(reply_q & reply_dout_q), $sampled(stat_q), $sampled(msg_q));
		fail_cnt++;
	end

	// No stall on the download side
	a_dl_spacing: assert property (@(posedge clk_sys) !reset && dl_wr |=> !dl_wr [*3])
	else begin
		$error("ERROR %0t dl_wr pulses came closer than four cycles apart", $time);
		fail_cnt++;
	end

endmodule

bind cd_link_top cd_link_chk #(.CNT_W(CNT_W)) u_chk (.*);

`default_nettype wire

// ==== sim/tb_cd_link.sv ====
// Testbench for the CD link with request, reply and sector download stimulus
`timescale 1ns/1ps
`default_nettype none

module tb_cd_link;
	import cd_link_pkg::*;

	localparam int CNT_W    = 8;
	localparam int TIMEOUT  = 200;
	localparam int EV_MSG   = 0;
	localparam int EV_PULSE = 1;
	localparam int EV_BYTE  = 2;

	logic              clk_sys, reset;
	logic              cmd_send, dout_send, drive_reset_req, fast_seek;
	logic [CMD_W-1:0]  cmd_data;
	logic [DOUT_W-1:0] dout_data;
	host_msg_t         host_out;
	host_reply_t       host_in;
	logic [7:0]        drive_stat, drive_msg, cd_byte;
	logic              stat_get, dout_req, cd_byte_wr, data_mode;
	logic [CNT_W-1:0]  stat_cnt, comm_cnt;
	logic              dl_active, dl_wr;
	logic [15:0]       dl_word;

	integer     seed;
	logic [7:0] exp_bytes[$];
	logic [7:0] exp_byte;
	logic       last_toggle = 1'b0;
	int         event_cnt[3] = '{0, 0, 0};
	string      ev_name[3] = '{"an outbound message", "a reply pulse", "byte strobes"};

	cd_link_top #(.CNT_W(CNT_W)) DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("Simulation FAILED");
		$fatal(1, "Run stopped on the first error");
	endtask

	// Inputs change 2 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic wait_events(input int kind, input int target);
		int cyc;
		cyc = 0;
		while (event_cnt[kind] < target) begin
			@(negedge clk_sys);
			cyc++;
			if (cyc > TIMEOUT) begin
				stop_with_failure($sformatf("Timeout waiting for %s", ev_name[kind]));
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Monitor, sampled mid cycle
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk_sys) begin
		if (DUT.u_chk.fail_cnt != 0) begin
			stop_with_failure("A checker assertion failed");
		end
		if (!reset) begin
			if (host_out.toggle != last_toggle) begin
				event_cnt[EV_MSG]++;
			end
			if (stat_get || dout_req) begin
				event_cnt[EV_PULSE]++;
			end
			if (cd_byte_wr) begin
				assert (exp_bytes.size() != 0)
					else stop_with_failure("Byte strobe beyond the sector length");
				exp_byte = exp_bytes.pop_front();
				assert (cd_byte == exp_byte) else stop_with_failure($sformatf(
					"ERROR %0t cd_byte got %02h exp %02h", $time, cd_byte, exp_byte));
				event_cnt[EV_BYTE]++;
			end
		end
		last_toggle = host_out.toggle;
	end

	task automatic raise_requests(input logic cmd, input logic dout, input logic drv_rst);
		int msgs;
		msgs            = event_cnt[EV_MSG];
		fast_seek       = 1'($random(seed));
		cmd_data        = {$random(seed), $random(seed), $random(seed)};
		dout_data       = 80'({$random(seed), $random(seed), $random(seed)});
		cmd_send        = cmd;
		dout_send       = dout;
		drive_reset_req = drv_rst;
		wait_events(EV_MSG, msgs + 1);
		// Held high for a while, no second message
		repeat (3) next_cycle();
		cmd_send        = 1'b0;
		dout_send       = 1'b0;
		drive_reset_req = 1'b0;
		next_cycle();
	endtask

	task automatic send_reply(input logic dataout);
		int pulses;
		pulses             = event_cnt[EV_PULSE];
		host_in.stat       = 8'($random(seed));
		host_in.msg        = 8'($random(seed));
		host_in.is_dataout = dataout;
		host_in.toggle     = ~host_in.toggle;
		wait_events(EV_PULSE, pulses + 1);
		next_cycle();
	endtask

	// Header first, then more words than the length needs
	task automatic run_download(input logic mode, input int len);
		logic [15:0] word;
		int          i;
		exp_bytes.delete();
		event_cnt[EV_BYTE] = 0;
		dl_active = 1'b1;
		repeat (2) next_cycle();
		for (i = 0; i <= len / 2 + 2; i++) begin
			word = 16'($random(seed));
			if (i == 0) begin
				word = {mode, 15'(len)};
			end else begin
				if (2 * i - 2 < len) begin
					exp_bytes.push_back(word[7:0]);
				end
				if (2 * i - 1 < len) begin
					exp_bytes.push_back(word[15:8]);
				end
			end
			dl_word = word;
			dl_wr   = 1'b1;
			next_cycle();
			dl_wr   = 1'b0;
			repeat (3) next_cycle();
		end
		wait_events(EV_BYTE, len);
		repeat (4) next_cycle();
		assert (event_cnt[EV_BYTE] == len && exp_bytes.size() == 0) else stop_with_failure(
			$sformatf("ERROR %0t byte strobes got %0d exp %0d", $time, event_cnt[EV_BYTE], len));
		assert (data_mode == mode) else stop_with_failure(
			$sformatf("ERROR %0t data_mode got %b exp %b", $time, data_mode, mode));
		dl_active = 1'b0;
		next_cycle();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		seed            = 32'h4ba90253;
		reset           = 1'b1;
		cmd_send        = 1'b0;
		cmd_data        = '0;
		dout_send       = 1'b0;
		dout_data       = '0;
		drive_reset_req = 1'b0;
		fast_seek       = 1'b0;
		host_in         = '0;
		dl_active       = 1'b0;
		dl_wr           = 1'b0;
		dl_word         = '0;
		repeat (2) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		next_cycle();

		repeat (4) raise_requests(1'b1, 1'b0, 1'b0);
		// Data-out beats drive reset, command beats both
		raise_requests(1'b0, 1'b1, 1'b1);
		raise_requests(1'b0, 1'b0, 1'b1);
		raise_requests(1'b1, 1'b1, 1'b1);

		send_reply(1'b0);
		send_reply(1'b1);
		send_reply(1'b1);
		send_reply(1'b0);

		run_download(1'b1, 7);
		run_download(1'b0, 10);

		repeat (4) next_cycle();
		if (DUT.u_chk.fail_cnt == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			stop_with_failure("Checker assertions failed during the run");
		end
	end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/cd_link_pkg.sv
verilog/cd_msg_tx.sv
verilog/cd_msg_rx.sv
verilog/cd_sector_unpack.sv
verilog/cd_link_top.sv
sim/cd_link_chk.sv
sim/tb_cd_link.sv

// ==== verilog/cd_link_pkg.sv ====
// Message kinds, unpacker states, payload widths and host message structs
`default_nettype none

package cd_link_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	// Command block from the CD controller
	localparam int CMD_W = 96;

	// Data-out block, sits in the low bits of the payload
	localparam int DOUT_W = 80;

	// Sector length field in the download header word
	localparam int LEN_W = 15;

	//////////////////////////////////////////////////////////////////////
	// Outbound message kinds
	//////////////////////////////////////////////////////////////////////

	// Bit 15 of a command kind carries the fast seek flag
	typedef enum logic [15:0] {
		MSG_COMMAND = 16'h0000,
		MSG_DATAOUT = 16'h0001,
		MSG_RESET   = 16'h00FF
	} msg_kind_e;

	// Core to host, new message on every toggle change
	typedef struct packed {
		logic              toggle;
		msg_kind_e         kind;
		logic [CMD_W-1:0]  payload;
	} host_msg_t;

	// Host to core
	typedef struct packed {
		logic        toggle;
		logic        is_dataout;
		logic [7:0]  stat;
		logic [7:0]  msg;
	} host_reply_t;

	//////////////////////////////////////////////////////////////////////
	// Sector download unpacker
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		UNP_HEADER,
		UNP_DATA,
		UNP_STROBE,
		UNP_GAP
	} unpack_state_e;

endpackage

`default_nettype wire

// ==== verilog/cd_link_top.sv ====
// CD link top level with message bridge and sector download unpacker
`timescale 1ns/1ps
`default_nettype none

module cd_link_top
	import cd_link_pkg::*;
#(
	parameter int CNT_W = 8
) (
	input  logic              clk_sys,
	input  logic              reset,

	// Core side requests
	input  logic              cmd_send,
	input  logic [CMD_W-1:0]  cmd_data,
	input  logic              dout_send,
	input  logic [DOUT_W-1:0] dout_data,
	input  logic              drive_reset_req,
	input  logic              fast_seek,

	// Host message link
	output host_msg_t         host_out,
	input  host_reply_t       host_in,

	// Core side replies
	output logic [7:0]        drive_stat,
	output logic [7:0]        drive_msg,
	output logic              stat_get,
	output logic              dout_req,
	output logic [CNT_W-1:0]  stat_cnt,
	output logic [CNT_W-1:0]  comm_cnt,

	// Sector download
	input  logic              dl_active,
	input  logic              dl_wr,
	input  logic [15:0]       dl_word,
	output logic [7:0]        cd_byte,
	output logic              cd_byte_wr,
	output logic              data_mode
);

	logic cmd_sent;

	cd_msg_tx u_msg_tx (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.cmd_send        (cmd_send),
		.cmd_data        (cmd_data),
		.dout_send       (dout_send),
		.dout_data       (dout_data),
		.drive_reset_req (drive_reset_req),
		.fast_seek       (fast_seek),
		.host_out        (host_out),
		.cmd_sent        (cmd_sent)
	);

	cd_msg_rx #(
		.CNT_W (CNT_W)
	) u_msg_rx (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.host_in    (host_in),
		.cmd_sent   (cmd_sent),
		.drive_stat (drive_stat),
		.drive_msg  (drive_msg),
		.stat_get   (stat_get),
		.dout_req   (dout_req),
		.stat_cnt   (stat_cnt),
		.comm_cnt   (comm_cnt)
	);

	cd_sector_unpack u_sector_unpack (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_active  (dl_active),
		.dl_wr      (dl_wr),
		.dl_word    (dl_word),
		.cd_byte    (cd_byte),
		.cd_byte_wr (cd_byte_wr),
		.data_mode  (data_mode)
	);

endmodule

`default_nettype wire

// ==== verilog/cd_msg_rx.sv ====
// Inbound CD message capture, status and data-out request pulses, message counters
`timescale 1ns/1ps
`default_nettype none

module cd_msg_rx
	import cd_link_pkg::*;
#(
	parameter int CNT_W = 8
) (
	input  logic             clk_sys,
	input  logic             reset,

	input  host_reply_t      host_in,
	input  logic             cmd_sent,

	output logic [7:0]       drive_stat,
	output logic [7:0]       drive_msg,
	output logic             stat_get,
	output logic             dout_req,
	output logic [CNT_W-1:0] stat_cnt,
	output logic [CNT_W-1:0] comm_cnt
);

	logic toggle_q;
	logic new_reply;

	// Host marks a new reply by flipping its toggle
	assign new_reply = host_in.toggle != toggle_q;

	//////////////////////////////////////////////////////////////////////
	// Control and counters
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		stat_get <= 1'b0;
		dout_req <= 1'b0;
		if (reset) begin
			toggle_q <= 1'b0;
			stat_cnt <= '0;
			comm_cnt <= '0;
		end else begin
			if (new_reply) begin
				toggle_q <= host_in.toggle;
				stat_get <= ~host_in.is_dataout;
				dout_req <= host_in.is_dataout;
				stat_cnt <= stat_cnt + 1'b1;
			end

			// Counters wrap
			if (cmd_sent) begin
				comm_cnt <= comm_cnt + 1'b1;
			end
		end
	end

	// Status bytes
	always_ff @(posedge clk_sys) begin
		if (!reset && new_reply) begin
			drive_stat <= host_in.stat;
			drive_msg  <= host_in.msg;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/cd_msg_tx.sv ====
// Outbound CD message builder with request edge detection and priority
`timescale 1ns/1ps
`default_nettype none

module cd_msg_tx
	import cd_link_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,

	// Core requests, levels
	input  logic              cmd_send,
	input  logic [CMD_W-1:0]  cmd_data,
	input  logic              dout_send,
	input  logic [DOUT_W-1:0] dout_data,
	input  logic              drive_reset_req,
	input  logic              fast_seek,

	// To host
	output host_msg_t         host_out,
	output logic              cmd_sent
);

	logic cmd_send_q;
	logic dout_send_q;
	logic drive_reset_q;

	logic cmd_rise;
	logic dout_rise;
	logic drive_reset_rise;

	// Only the first sampled high level of each request counts
	assign cmd_rise         = cmd_send & ~cmd_send_q;
	assign dout_rise        = dout_send & ~dout_send_q;
	assign drive_reset_rise = drive_reset_req & ~drive_reset_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cmd_send_q    <= 1'b0;
			dout_send_q   <= 1'b0;
			drive_reset_q <= 1'b0;
		end else begin
			cmd_send_q    <= cmd_send;
			dout_send_q   <= dout_send;
			drive_reset_q <= drive_reset_req;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Message build
	//////////////////////////////////////////////////////////////////////

	// Command wins over data-out, data-out over reset
	// Lower edges on the same clock are dropped
	always_ff @(posedge clk_sys) begin
		cmd_sent <= 1'b0;
		if (reset) begin
			host_out.toggle <= 1'b0;
		end else if (cmd_rise) begin
			host_out.payload <= cmd_data;
			host_out.kind    <= msg_kind_e'(MSG_COMMAND | {fast_seek, 15'd0});
			host_out.toggle  <= ~host_out.toggle;
			cmd_sent         <= 1'b1;
		end else if (dout_rise) begin
			// Upper payload bits keep whatever the last command left
			host_out.payload[DOUT_W-1:0] <= dout_data;
			host_out.kind                <= MSG_DATAOUT;
			host_out.toggle              <= ~host_out.toggle;
		end else if (drive_reset_rise) begin
			host_out.kind   <= MSG_RESET;
			host_out.toggle <= ~host_out.toggle;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/cd_sector_unpack.sv ====
// Sector download unpacker with header parse and word to byte write sequencing
`timescale 1ns/1ps
`default_nettype none

module cd_sector_unpack
	import cd_link_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,

	// Download stream from host
	input  logic        dl_active,
	input  logic        dl_wr,
	input  logic [15:0] dl_word,

	// Byte writes to the core
	output logic [7:0]  cd_byte,
	output logic        cd_byte_wr,
	output logic        data_mode
);

	unpack_state_e    state;

	logic             dl_active_q;
	logic             dl_start;
	logic [15:0]      word_q;
	logic [LEN_W-1:0] len_q;
	logic [LEN_W-1:0] byte_cnt;
	logic             byte_sel;
	logic             len_left;
	logic             word_take;

	assign dl_start = dl_active & ~dl_active_q;
	assign len_left = byte_cnt < len_q;

	// A new word is taken in DATA, or right in the last gap of the previous word
	// so that words four cycles apart are never lost
	assign word_take = dl_active & dl_wr & len_left &
		((state == UNP_DATA) | ((state == UNP_GAP) & byte_sel));

	// Low byte first
	assign cd_byte = byte_sel ? word_q[15:8] : word_q[7:0];

	//////////////////////////////////////////////////////////////////////
	// FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= UNP_HEADER;
			dl_active_q <= 1'b0;
			cd_byte_wr  <= 1'b0;
			byte_cnt    <= '0;
			byte_sel    <= 1'b0;
			data_mode   <= 1'b0;
		end else begin
			dl_active_q <= dl_active;

			if (dl_start) begin
				// New download always starts with a header
				state      <= UNP_HEADER;
				cd_byte_wr <= 1'b0;
				byte_cnt   <= '0;
				byte_sel   <= 1'b0;
			end else begin
				case (state)
					UNP_HEADER: begin
						if (dl_active && dl_wr) begin
							data_mode <= dl_word[15];
							byte_cnt  <= '0;
							state     <= UNP_DATA;
						end
					end

					UNP_DATA: begin
						if (word_take) begin
							byte_sel <= 1'b0;
							state    <= UNP_STROBE;
						end
					end

					UNP_STROBE: begin
						cd_byte_wr <= 1'b1;
						byte_cnt   <= byte_cnt + 1'b1;
						state      <= UNP_GAP;
					end

					UNP_GAP: begin
						cd_byte_wr <= 1'b0;
						if (word_take) begin
							byte_sel <= 1'b0;
							state    <= UNP_STROBE;
						end else if (!byte_sel && len_left) begin
							// High byte of the same word
							byte_sel <= 1'b1;
							state    <= UNP_STROBE;
						end else begin
							state <= UNP_DATA;
						end
					end

					default: begin
						state <= UNP_HEADER;
					end
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Header length and data word
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!dl_start && state == UNP_HEADER && dl_active && dl_wr) begin
			len_q <= dl_word[LEN_W-1:0];
		end
		if (!dl_start && word_take) begin
			word_q <= dl_word;
		end
	end

endmodule

`default_nettype wire
